//--- bench/alu_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_cluster_tb;
	import alu_pkg::*;

	localparam int NUM_RANDOM = 40;
	localparam int DEPTH      = `CMD_QUEUE_DEPTH;

	logic                  clk;
	logic                  arst_n;
	logic                  cmd_valid_0;
	logic [3:0]            cmd_op_0;
	logic [`ALU_WIDTH-1:0] cmd_a_0;
	logic [`ALU_WIDTH-1:0] cmd_b_0;
	logic                  credit_0;
	logic                  cmd_valid_1;
	logic [3:0]            cmd_op_1;
	logic [`ALU_WIDTH-1:0] cmd_a_1;
	logic [`ALU_WIDTH-1:0] cmd_b_1;
	logic                  credit_1;
	logic                  res_valid;
	port_id_t              res_port;
	logic [`ALU_WIDTH-1:0] res_out;
	logic [`ALU_WIDTH-1:0] res_ext;
	logic                  res_carry;
	logic                  res_zero;
	logic                  res_sign;
	logic                  res_overflow;

	// stimulus table with one entry per command
	string                 names [$];
	port_id_t              ports [$];
	logic [3:0]            ops [$];
	logic [`ALU_WIDTH-1:0] opa [$];
	logic [`ALU_WIDTH-1:0] opb [$];
	alu_result_t           exps [$];

	int     pend_0 [$];   // table index of commands in flight
	int     pend_1 [$];
	int     credits [2];
	int     seen     = 0;
	int     total    = 0;
	int     n_table  = 0;
	int     failures = 0;
	integer seed     = 32'h0ad26039;

	tb_clock_gen u_clk (.clk (clk));

	alu_cluster_top alu_cluster_top_i (
		.clk (clk), .arst_n (arst_n),
		.cmd_valid_0 (cmd_valid_0), .cmd_op_0 (cmd_op_0), .cmd_a_0 (cmd_a_0),
		.cmd_b_0 (cmd_b_0), .credit_0 (credit_0),
		.cmd_valid_1 (cmd_valid_1), .cmd_op_1 (cmd_op_1), .cmd_a_1 (cmd_a_1),
		.cmd_b_1 (cmd_b_1), .credit_1 (credit_1),
		.res_valid (res_valid), .res_port (res_port), .res_out (res_out),
		.res_ext (res_ext), .res_carry (res_carry), .res_zero (res_zero),
		.res_sign (res_sign), .res_overflow (res_overflow)
	);

	//////////////////////////////
	// error handling and compares

	task automatic stop_run;
		failures++;
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_result(input string name, input alu_result_t exp, input alu_result_t act);
		if (act.out !== exp.out || act.out_ext !== exp.out_ext)
		begin
			$display("mismatch %s result (ext:out): expected %h:%h actual %h:%h",
				name, exp.out_ext, exp.out, act.out_ext, act.out);
			stop_run();
		end
	endtask

	task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
		if (act !== exp)
		begin
			$display("mismatch %s flags (c z s o): expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_port(input string name, input port_id_t exp, input port_id_t act);
		if (act !== exp)
		begin
			$display("mismatch %s port: expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	//////////////////////////////
	// reference behavior

	function automatic alu_result_t expected_result(input logic [3:0] op,
		input logic [31:0] a, input logic [31:0] b);
		alu_result_t        r;
		logic [32:0]        sum;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        prod;
		r  = '0;
		sa = {{32{a[31]}}, a};   // sign extended to 64 bits
		sb = {{32{b[31]}}, b};
		case (op)
			op_neg:    r.out = 32'd0 - b;
			op_and:    r.out = a & b;
			op_xor:    r.out = a ^ b;
			op_shl:    r.out = a << b[4:0];
			op_shr:    r.out = a >> b[4:0];
			op_sra:    r.out = $signed(a) >>> b[4:0];
			op_pass_a: r.out = a;
			op_pass_b: r.out = b;
			op_add:
			begin
				sum = {1'b0, a} + {1'b0, b};
				r.out = sum[31:0];
				r.flags.carry    = sum[32];
				r.flags.sign     = sum[31];
				r.flags.overflow = sum[32];
			end
			op_add_ofs:
			begin
				sum = {1'b0, a} + {17'd0, b[15:0]};
				r.out = sum[31:0];
				r.flags.carry = sum[32];
			end
			op_mul:
			begin
				prod = sa * sb;
				{r.out_ext, r.out} = prod;
				r.flags.sign = a[31] ^ b[31];
			end
			op_mulu:
				{r.out_ext, r.out} = {32'd0, a} * {32'd0, b};
			default: r = '0;   // codes 12 to 15
		endcase
		r.flags.zero = ({r.out_ext, r.out} == 64'd0);
		return r;
	endfunction

	//////////////////////////////
	// table building

	task automatic add_row(input string name, input port_id_t port, input logic [3:0] op,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] out,
		input logic [31:0] ext, input logic [3:0] flags);
		alu_result_t r;
		r.out     = out;
		r.out_ext = ext;
		r.flags   = alu_flags_t'(flags);
		names.push_back(name);
		ports.push_back(port);
		ops.push_back(op);
		opa.push_back(a);
		opb.push_back(b);
		exps.push_back(r);
	endtask

	// flags column is carry, zero, sign, overflow
	task automatic fill_table;
		add_row("neg_one",    1'b0, op_neg, 32'h0, 32'h1, 32'hffffffff, 32'h0, 4'b0000);
		add_row("neg_zero",   1'b1, op_neg, 32'h5, 32'h0, 32'h0, 32'h0, 4'b0100);
		add_row("and_mask",   1'b0, op_and, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 32'h0, 4'b0000);
		add_row("xor_mix",    1'b1, op_xor, 32'haaaa5555, 32'hffff0000, 32'h55555555, 32'h0, 4'b0000);
		add_row("pass_a",     1'b0, op_pass_a, 32'h80000000, 32'h1, 32'h80000000, 32'h0, 4'b0000);
		add_row("pass_b",     1'b1, op_pass_b, 32'h1, 32'h12345678, 32'h12345678, 32'h0, 4'b0000);
		add_row("shl_by_0",   1'b0, op_shl, 32'hdeadbeef, 32'hffffffe0, 32'hdeadbeef, 32'h0, 4'b0000);
		add_row("shl_by_31",  1'b0, op_shl, 32'h3, 32'h1f, 32'h80000000, 32'h0, 4'b0000);
		add_row("shr_by_31",  1'b1, op_shr, 32'h80000000, 32'hffffffff, 32'h1, 32'h0, 4'b0000);
		add_row("sra_neg_4",  1'b1, op_sra, 32'h80000000, 32'h4, 32'hf8000000, 32'h0, 4'b0000);
		add_row("sra_neg_31", 1'b0, op_sra, 32'h80000001, 32'h1f, 32'hffffffff, 32'h0, 4'b0000);
		add_row("sra_pos_1",  1'b1, op_sra, 32'h7ffffffe, 32'h1, 32'h3fffffff, 32'h0, 4'b0000);
		add_row("add_plain",  1'b0, op_add, 32'h1, 32'h2, 32'h3, 32'h0, 4'b0000);
		add_row("add_carry",  1'b1, op_add, 32'hffffffff, 32'h2, 32'h1, 32'h0, 4'b1001);
		add_row("add_sign",   1'b0, op_add, 32'h7fffffff, 32'h1, 32'h80000000, 32'h0, 4'b0010);
		add_row("add_wrap",   1'b1, op_add, 32'h80000000, 32'h80000000, 32'h0, 32'h0, 4'b1101);
		add_row("ofs_hi_b",   1'b0, op_add_ofs, 32'h10, 32'hffff0005, 32'h15, 32'h0, 4'b0000);
		add_row("ofs_carry",  1'b1, op_add_ofs, 32'hffffffff, 32'habcd0001, 32'h0, 32'h0, 4'b1100);
		add_row("mul_pp",     1'b0, op_mul, 32'h3, 32'h5, 32'hf, 32'h0, 4'b0000);
		add_row("mul_pn",     1'b0, op_mul, 32'h3, 32'hfffffffb, 32'hfffffff1, 32'hffffffff, 4'b0010);
		add_row("mul_np",     1'b1, op_mul, 32'hfffffffe, 32'h10000, 32'hfffe0000, 32'hffffffff, 4'b0010);
		add_row("mul_nn",     1'b1, op_mul, 32'hffffffff, 32'hffffffff, 32'h1, 32'h0, 4'b0000);
		add_row("mul_ext",    1'b0, op_mul, 32'h80000000, 32'h80000000, 32'h0, 32'h40000000, 4'b0000);
		add_row("mul_zero",   1'b1, op_mul, 32'h0, 32'hffffffff, 32'h0, 32'h0, 4'b0110);
		add_row("mulu_max",   1'b0, op_mulu, 32'hffffffff, 32'hffffffff, 32'h1, 32'hfffffffe, 4'b0000);
		add_row("mulu_ext",   1'b1, op_mulu, 32'h80000000, 32'h2, 32'h0, 32'h1, 4'b0000);
		add_row("mulu_pp",    1'b0, op_mulu, 32'h10001, 32'h10001, 32'h20001, 32'h1, 4'b0000);
		add_row("mulu_pn",    1'b1, op_mulu, 32'h3, 32'hfffffffb, 32'hfffffff1, 32'h2, 4'b0000);
		add_row("undef_12",   1'b0, 4'd12, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 4'b0100);
		add_row("undef_13",   1'b1, 4'd13, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 4'b0100);
		add_row("undef_14",   1'b0, 4'd14, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 4'b0100);
		add_row("undef_15",   1'b1, 4'd15, 32'hffffffff, 32'hffffffff, 32'h0, 32'h0, 4'b0100);
	endtask

	task automatic make_random_rows(input int count);
		logic [31:0] sel;
		logic [31:0] a;
		logic [31:0] b;
		alu_result_t r;
		for (int i = 0; i < count; i++)
		begin
			sel = $random(seed);
			a   = $random(seed);
			b   = $random(seed);
			r   = expected_result(sel[3:0], a, b);
			add_row($sformatf("random_%0d", i), sel[4], sel[3:0], a, b, r.out, r.out_ext,
				r.flags);
		end
	endtask

	//////////////////////////////
	// driving and monitoring

	task automatic push_row(input int idx);
		if (ports[idx] == 1'b0)
		begin
			cmd_valid_0 = 1'b1;
			cmd_op_0    = ops[idx];
			cmd_a_0     = opa[idx];
			cmd_b_0     = opb[idx];
			pend_0.push_back(idx);
		end
		else
		begin
			cmd_valid_1 = 1'b1;
			cmd_op_1    = ops[idx];
			cmd_a_1     = opa[idx];
			cmd_b_1     = opb[idx];
			pend_1.push_back(idx);
		end
		credits[ports[idx]]--;   // spent on push
	endtask

	// at most one push per port each cycle in table order
	task automatic send_rows(input int first, input int last);
		int         idx;
		logic [1:0] used;
		idx = first;
		while (idx < last)
		begin
			@(posedge clk);
			#10;
			cmd_valid_0 = 1'b0;
			cmd_valid_1 = 1'b0;
			used = 2'b00;
			while (idx < last && !used[ports[idx]] && credits[ports[idx]] > 0)
			begin
				used[ports[idx]] = 1'b1;
				push_row(idx);
				idx++;
			end
		end
		@(posedge clk);
		#10;
		cmd_valid_0 = 1'b0;
		cmd_valid_1 = 1'b0;
	endtask

	task automatic take_result;
		int          idx;
		port_id_t    src;
		alu_result_t act;
		act.out            = res_out;
		act.out_ext        = res_ext;
		act.flags.carry    = res_carry;
		act.flags.zero     = res_zero;
		act.flags.sign     = res_sign;
		act.flags.overflow = res_overflow;
		// the queue that issued this result returns its credit in the same cycle
		if (credit_0 == credit_1)
			fail_plain("result arrived without exactly one credit coming back");
		src = credit_1;
		if ((src == 1'b0 && pend_0.size() == 0) || (src == 1'b1 && pend_1.size() == 0))
			fail_plain($sformatf("credit came back on port %0d with no command pending", src));
		idx = (src == 1'b0) ? pend_0.pop_front() : pend_1.pop_front();
		check_port(names[idx], ports[idx], res_port);
		check_result(names[idx], exps[idx], act);
		check_flags(names[idx], exps[idx].flags, act.flags);
		seen++;
	endtask

	// credit returns and results at mid cycle
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			if (credit_0)
				credits[0]++;
			if (credit_1)
				credits[1]++;
			if (credits[0] > DEPTH || credits[1] > DEPTH)
				fail_plain("more credits came back than the queue depth");
			if (res_valid)
				take_result();
		end
	end

	//////////////////////////////
	// main sequence and watchdog

	initial
	begin : main
		arst_n      = 1'b0;
		cmd_valid_0 = 1'b0;
		cmd_op_0    = 4'd0;
		cmd_a_0     = '0;
		cmd_b_0     = '0;
		cmd_valid_1 = 1'b0;
		cmd_op_1    = 4'd0;
		cmd_a_1     = '0;
		cmd_b_1     = '0;
		credits[0]  = DEPTH;
		credits[1]  = DEPTH;
		fill_table();
		n_table = names.size();
		make_random_rows(NUM_RANDOM);
		total = names.size();
		repeat (4) @(posedge clk);
		#10;
		arst_n = 1'b1;
		@(negedge clk);
		if (res_valid || credit_0 || credit_1)
			fail_plain("result valid or credit high right after reset");
		send_rows(0, n_table);
		send_rows(n_table, total);
		wait (seen == total && credits[0] == DEPTH && credits[1] == DEPTH);
		repeat (3) @(posedge clk);   // catch stray results
		if (failures == 0 && seen == total && pend_0.size() == 0 && pend_1.size() == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Something failed");
			$fatal(1, "results incomplete at end of run");
		end
	end

	initial
	begin : watchdog
		wait (total > 0);
		repeat (total * 10) @(posedge clk);
		$display("results did not arrive in time, %0d of %0d seen", seen, total);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock
module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);
	initial
		clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the alu cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=alu_cluster_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module alu_cluster_tb \
	-f sources.f \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Something failed" "$LOG_FILE"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

echo "simulation passed"
exit 0

//--- source/alu_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_cluster_top (
	input  logic                  clk,
	input  logic                  arst_n,
	// port 0
	input  logic                  cmd_valid_0,
	input  logic [3:0]            cmd_op_0,
	input  logic [`ALU_WIDTH-1:0] cmd_a_0,
	input  logic [`ALU_WIDTH-1:0] cmd_b_0,
	output logic                  credit_0,
	// port 1
	input  logic                  cmd_valid_1,
	input  logic [3:0]            cmd_op_1,
	input  logic [`ALU_WIDTH-1:0] cmd_a_1,
	input  logic [`ALU_WIDTH-1:0] cmd_b_1,
	output logic                  credit_1,
	// result bus
	output logic                  res_valid,
	output alu_pkg::port_id_t     res_port,
	output logic [`ALU_WIDTH-1:0] res_out,
	output logic [`ALU_WIDTH-1:0] res_ext,
	output logic                  res_carry,
	output logic                  res_zero,
	output logic                  res_sign,
	output logic                  res_overflow
);
	import alu_pkg::*;

	alu_cmd_t    push_cmd_0;
	alu_cmd_t    push_cmd_1;
	logic        issue_valid;
	alu_cmd_t    issue_cmd;
	port_id_t    issue_port;
	alu_result_t result;

	// undefined op codes pass through unchanged
	assign push_cmd_0 = '{op: alu_op_t'(cmd_op_0), a: cmd_a_0, b: cmd_b_0};
	assign push_cmd_1 = '{op: alu_op_t'(cmd_op_1), a: cmd_a_1, b: cmd_b_1};

	alu_issue_if if_0 ();
	alu_issue_if if_1 ();

	cmd_queue u_queue_0 (
		.clk (clk), .arst_n (arst_n), .push (cmd_valid_0), .push_cmd (push_cmd_0),
		.credit (credit_0), .issue (if_0.queue)
	);

	cmd_queue u_queue_1 (
		.clk (clk), .arst_n (arst_n), .push (cmd_valid_1), .push_cmd (push_cmd_1),
		.credit (credit_1), .issue (if_1.queue)
	);

	issue_arbiter u_arbiter (
		.clk (clk), .arst_n (arst_n), .port0 (if_0.arbiter), .port1 (if_1.arbiter),
		.issue_valid (issue_valid), .issue_cmd (issue_cmd), .issue_port (issue_port)
	);

	alu_core u_core (
		.clk (clk), .arst_n (arst_n), .issue_valid (issue_valid), .issue_cmd (issue_cmd),
		.issue_port (issue_port), .res_valid (res_valid), .res_port (res_port),
		.result (result)
	);

	//////////////////////////////
	// result struct onto plain ports

	assign res_out      = result.out;
	assign res_ext      = result.out_ext;
	assign res_carry    = result.flags.carry;
	assign res_zero     = result.flags.zero;
	assign res_sign     = result.flags.sign;
	assign res_overflow = result.flags.overflow;

endmodule

`default_nettype wire

//--- source/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand width of the datapath
`define ALU_WIDTH 32

// entries per command queue and initial credits per port
`define CMD_QUEUE_DEPTH 4

// number of peer issue ports
`define NUM_ISSUE_PORTS 2

`endif

//--- source/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module alu_core (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 issue_valid,
	input  alu_pkg::alu_cmd_t    issue_cmd,
	input  alu_pkg::port_id_t    issue_port,
	output logic                 res_valid,
	output alu_pkg::port_id_t    res_port,
	output alu_pkg::alu_result_t result
);
	import alu_pkg::*;

	localparam int W = `ALU_WIDTH;

	alu_op_t       op;
	logic [W-1:0]  a;
	logic [W-1:0]  b;
	logic [1:0]    shift_mode;
	logic [W-1:0]  shift_out;
	logic [W:0]    add_sum;
	logic [W:0]    ofs_sum;
	logic          signed_mul;
	logic          neg_prod;
	logic [W-1:0]  mul_a;
	logic [W-1:0]  mul_b;
	logic [2*W-1:0] prod;
	logic [2*W-1:0] prod_fix;
	logic          is_logic;
	alu_result_t   nxt;

	assign op = issue_cmd.op;
	assign a  = issue_cmd.a;
	assign b  = issue_cmd.b;

	//////////////////////////////
	// shifter, adders, multiplier

	assign shift_mode = {op == op_sra, (op == op_shr) || (op == op_sra)};

	barrel_shifter u_shift (
		.value   (a),
		.amount  (b[4:0]),
		.mode    (shift_mode),
		.shifted (shift_out)
	);

	assign add_sum = {1'b0, a} + {1'b0, b};
	assign ofs_sum = {1'b0, a} + {{(W-15){1'b0}}, b[15:0]};   // upper half of b ignored

	// signed mul goes through magnitudes on the one unsigned multiplier
	assign signed_mul = (op == op_mul);
	assign mul_a      = (signed_mul && a[W-1]) ? (~a + 1'b1) : a;
	assign mul_b      = (signed_mul && b[W-1]) ? (~b + 1'b1) : b;
	assign prod       = (2*W)'(mul_a) * (2*W)'(mul_b);
	assign neg_prod   = signed_mul && (a[W-1] ^ b[W-1]);
	assign prod_fix   = neg_prod ? (~prod + 1'b1) : prod;

	assign is_logic = op inside {op_neg, op_and, op_xor, op_shl, op_shr, op_sra,
		op_pass_a, op_pass_b};

	//////////////////////////////
	// operation select and flags

	always_comb
	begin
		nxt = '0;   // covers undefined opcodes too
		case (op)
			op_neg:    nxt.out = ~b + 1'b1;
			op_and:    nxt.out = a & b;
			op_xor:    nxt.out = a ^ b;
			op_shl,
			op_shr,
			op_sra:    nxt.out = shift_out;
			op_add:
			begin
				{nxt.flags.carry, nxt.out} = add_sum;
				nxt.flags.sign     = add_sum[W-1];
				nxt.flags.overflow = add_sum[W];   // mirrors carry
			end
			op_mul,
			op_mulu:
			begin
				{nxt.out_ext, nxt.out} = prod_fix;
				nxt.flags.sign = neg_prod;   // zero for mulu
			end
			op_pass_a: nxt.out = a;
			op_pass_b: nxt.out = b;
			op_add_ofs:
				{nxt.flags.carry, nxt.out} = ofs_sum;
			default:   nxt.out = '0;
		endcase
		nxt.flags.zero = ({nxt.out_ext, nxt.out} == '0);
	end

	//////////////////////////////
	// result register

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			res_valid <= 1'b0;
		else
			res_valid <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		if (issue_valid)
		begin
			result   <= nxt;
			res_port <= issue_port;
		end
	end

	a_logic_flags: assert property (
		@(posedge clk) disable iff (!arst_n)
		(issue_valid && is_logic) |=> (!result.flags.sign && !result.flags.overflow)
	) else $error("alu_core: sign or overflow set by a logic op");

endmodule

`default_nettype wire

//--- source/alu_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// one command queue talking to the shared arbiter
interface alu_issue_if;
	import alu_pkg::*;

	logic     req;    // queue holds at least one command
	alu_cmd_t cmd;    // head of queue
	logic     grant;  // arbiter picked this queue
	logic     fire;

	// the command moves on the edge closing this cycle
	assign fire = req && grant;

	modport queue (
		output req,
		output cmd,
		input  fire
	);

	modport arbiter (
		input  req,
		input  cmd,
		output grant
	);

endinterface

`default_nettype wire

//--- source/alu_pkg.sv
`default_nettype none

`include "alu_config.svh"

package alu_pkg;

	//////////////////////////////
	// opcodes

	// codes 12 to 15 unused
	typedef enum logic [3:0] {
		op_neg     = 4'd0,   // two's complement of b
		op_and     = 4'd1,
		op_xor     = 4'd2,
		op_shl     = 4'd3,
		op_shr     = 4'd4,
		op_add     = 4'd5,
		op_mul     = 4'd6,   // signed
		op_mulu    = 4'd7,
		op_sra     = 4'd8,
		op_pass_a  = 4'd9,
		op_pass_b  = 4'd10,
		op_add_ofs = 4'd11   // a + zero-extended b[15:0]
	} alu_op_t;

	//////////////////////////////
	// payloads

	typedef struct packed {
		logic carry;
		logic zero;
		logic sign;
		logic overflow;
	} alu_flags_t;

	typedef struct packed {
		alu_op_t               op;
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
	} alu_cmd_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] out;
		logic [`ALU_WIDTH-1:0] out_ext;   // upper product word
		alu_flags_t            flags;
	} alu_result_t;

	typedef logic [$clog2(`NUM_ISSUE_PORTS)-1:0] port_id_t;

endpackage

`default_nettype wire

//--- source/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

// mode[0] selects right shift, mode[1] fills right shifts with the sign
module barrel_shifter (
	input  logic [`ALU_WIDTH-1:0] value,
	input  logic [4:0]            amount,
	input  logic [1:0]            mode,
	output logic [`ALU_WIDTH-1:0] shifted
);
	localparam int W = `ALU_WIDTH;

	logic [W-1:0] stage [0:5];
	logic         fill;

	assign fill = mode[1] && mode[0] && value[W-1];

	// left shifts run through the right shifter bit-reversed
	assign stage[0] = mode[0] ? value : {<<{value}};

	//////////////////////////////
	// log stages 1, 2, 4, 8, 16

	for (genvar i = 0; i < 5; i++)
	begin : g_stage
		localparam int SH = 1 << i;

		assign stage[i+1] = amount[i] ? {{SH{fill}}, stage[i][W-1:SH]} : stage[i];
	end

	assign shifted = mode[0] ? stage[5] : {<<{stage[5]}};

endmodule

`default_nettype wire

//--- source/cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module cmd_queue #(
	parameter int DEPTH = `CMD_QUEUE_DEPTH
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  alu_pkg::alu_cmd_t push_cmd,
	output logic              credit,
	alu_issue_if.queue        issue
);
	import alu_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	alu_cmd_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	// pointer step with wrap at DEPTH
	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop       = issue.fire;
	assign issue.req = (count != '0);
	assign issue.cmd = mem[rd_ptr];

	//////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	//////////////////////////////
	// pointers, count, credit

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			credit <= pop;   // one credit back per pop
			if (push)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // idle or push+pop
			endcase
		end
	end

	// requester ran out of credits but pushed anyway
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!arst_n)
		push |-> (count != CNT_W'(DEPTH))
	) else $error("cmd_queue: push into full queue");

endmodule

`default_nettype wire

//--- source/issue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter (
	input  logic              clk,
	input  logic              arst_n,
	alu_issue_if.arbiter      port0,
	alu_issue_if.arbiter      port1,
	output logic              issue_valid,
	output alu_pkg::alu_cmd_t issue_cmd,
	output alu_pkg::port_id_t issue_port
);
	import alu_pkg::*;

	logic [1:0] req;
	logic [1:0] grant;
	port_id_t   last;     // port granted most recently
	port_id_t   pref;     // port with priority this cycle
	port_id_t   winner;

	assign req  = {port1.req, port0.req};
	assign pref = last + 1'b1;

	//////////////////////////////
	// round robin pick

	always_comb
	begin
		winner = pref;
		if (!req[pref])
			winner = ~pref;   // fall back to the other port
	end

	assign issue_valid = |req;
	assign grant       = issue_valid ? (2'b01 << winner) : 2'b00;
	assign port0.grant = grant[0];
	assign port1.grant = grant[1];

	assign issue_port = winner;
	assign issue_cmd  = winner ? port1.cmd : port0.cmd;

	// start with port 0 preferred
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			last <= port_id_t'(1);
		else if (issue_valid)
			last <= winner;
	end

	a_grant_legal: assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0(grant) && ((grant & ~req) == 2'b00)
	) else $error("issue_arbiter: bad grant %b for req %b", grant, req);

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/alu_pkg.sv
source/alu_issue_if.sv
source/cmd_queue.sv
source/issue_arbiter.sv
source/barrel_shifter.sv
source/alu_core.sv
source/alu_cluster_top.sv
bench/tb_clock_gen.sv
bench/alu_cluster_tb.sv
